// ==== simd_alu.f ====
source/simd_alu_pkg.sv
source/simd_lane_adder.sv
source/simd_arith.sv
source/simd_compare.sv
source/simd_result_sel.sv
source/simd_alu.sv
tests/simd_alu_props.sv
tests/simd_alu_tb.sv

// ==== tests/simd_alu_tb.sv ====
////////////////////
// Testbench for the packed-SIMD ALU
// Directed edge cases, then seeded random requests checked against a lane model
////////////////////
module simd_alu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import simd_alu_pkg::*;

  localparam int unsigned RNG_SEED     = 51719;
  localparam int          RESET_CYCLES = 16;
  localparam int          NUM_RANDOM   = 3000;
  localparam int          DRAIN_LIMIT  = 20;

  logic        clk_i;
  logic        arst_n_i;
  logic        valid_i;
  simd_req_t   req_i;
  logic        valid_o;
  simd_rsp_t   rsp_o;

  simd_req_t   pending[$];
  simd_rsp_t   held_rsp;
  int          checks;
  int          value_errors;
  int          protocol_errors;

  simd_alu DUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .valid_o  (valid_o),
    .rsp_o    (rsp_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////
  // Lane helpers
  ////////////////////
  function automatic int lane_bits(simd_width_e width);
    case (width)
      W8:      return 8;
      W16:     return 16;
      default: return 32;
    endcase
  endfunction

  // Same value in every lane
  function automatic logic [DATA_W-1:0] fill_lanes(simd_width_e width, longint lane_value);
    logic [DATA_W-1:0] value;
    longint            mask;
    int                w;
    w     = lane_bits(width);
    mask  = (longint'(1) << w) - 1;
    value = '0;
    for (int i = 0; i < DATA_W / w; i++) begin
      value = value | DATA_W'((lane_value & mask) << (i * w));
    end
    return value;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic simd_rsp_t model_response(simd_req_t req);
    simd_rsp_t rsp;
    int        w;
    longint    mask;
    longint    smax;
    longint    smin;
    longint    ua;
    longint    ub;
    longint    sa;
    longint    sb;
    longint    r;
    rsp  = '0;
    w    = lane_bits(req.width);
    mask = (longint'(1) << w) - 1;
    smax = (longint'(1) << (w - 1)) - 1;
    smin = -(longint'(1) << (w - 1));
    for (int i = 0; i < DATA_W / w; i++) begin
      ua = (longint'(req.operand_a) >> (i * w)) & mask;
      ub = (longint'(req.operand_b) >> (i * w)) & mask;
      sa = (ua > smax) ? ua - mask - 1 : ua;
      sb = (ub > smax) ? ub - mask - 1 : ub;
      case (req.op)
        OP_ADD:   r = ua + ub;
        OP_SUB:   r = ua - ub;
        OP_KADD,
        OP_KSUB: begin
          r = (req.op == OP_KADD) ? sa + sb : sa - sb;
          if (r > smax || r < smin) begin
            rsp.ov = 1'b1;
            r      = (r > smax) ? smax : smin;
          end
        end
        OP_UKADD: begin
          r = ua + ub;
          if (r > mask) begin
            rsp.ov = 1'b1;
            r      = mask;
          end
        end
        OP_UKSUB: begin
          r = ua - ub;
          if (r < 0) begin
            rsp.ov = 1'b1;
            r      = 0;
          end
        end
        // Exact value, then floor of half
        OP_RADD:   r = (sa + sb) >>> 1;
        OP_URADD:  r = (ua + ub) >>> 1;
        OP_RSUB:   r = (sa - sb) >>> 1;
        OP_URSUB:  r = (ua - ub) >>> 1;
        OP_CMPEQ:  r = (ua == ub) ? mask : 0;
        OP_SCMPLT: r = (sa < sb) ? mask : 0;
        OP_SCMPLE: r = (sa <= sb) ? mask : 0;
        OP_UCMPLT: r = (ua < ub) ? mask : 0;
        OP_UCMPLE: r = (ua <= ub) ? mask : 0;
        OP_SMIN:   r = (sa < sb) ? ua : ub;
        OP_SMAX:   r = (sa < sb) ? ub : ua;
        OP_UMIN:   r = (ua < ub) ? ua : ub;
        default:   r = (ua < ub) ? ub : ua;
      endcase
      rsp.result = rsp.result | DATA_W'((r & mask) << (i * w));
    end
    return rsp;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////
  function automatic simd_req_t make_req(simd_op_e op, simd_width_e width,
                                         logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    simd_req_t req;
    req.op        = op;
    req.width     = width;
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  // Lane extremes show up often enough to reach the clamps
  function automatic logic [DATA_W-1:0] pick_operand(simd_width_e width);
    logic [DATA_W-1:0] value;
    int                w;
    w = lane_bits(width);
    case ($urandom_range(0, 7))
      0:       value = fill_lanes(width, (longint'(1) << (w - 1)) - 1);
      1:       value = fill_lanes(width, longint'(1) << (w - 1));
      2:       value = '1;
      3:       value = '0;
      default: value = $urandom();
    endcase
    return value;
  endfunction

  task automatic drive_cycle(logic valid, simd_req_t req);
    @(posedge clk_i);
    #1;
    valid_i = valid;
    req_i   = req;
    if (valid) begin
      pending.push_back(req);
    end
  endtask

  task automatic send_edge_cases();
    simd_width_e       width;
    logic [DATA_W-1:0] one;
    logic [DATA_W-1:0] smax;
    logic [DATA_W-1:0] smin;
    int                w;
    for (int k = 0; k < 3; k++) begin
      width = simd_width_e'(k);
      w     = lane_bits(width);
      one   = fill_lanes(width, 1);
      smax  = fill_lanes(width, (longint'(1) << (w - 1)) - 1);
      smin  = fill_lanes(width, longint'(1) << (w - 1));
      drive_cycle(1'b1, make_req(OP_KADD, width, smax, one));
      drive_cycle(1'b1, make_req(OP_KSUB, width, smin, one));
      drive_cycle(1'b1, make_req(OP_UKADD, width, '1, one));
      drive_cycle(1'b1, make_req(OP_UKSUB, width, '0, one));
      drive_cycle(1'b1, make_req(OP_ADD, width, '1, one));
      drive_cycle(1'b1, make_req(OP_SUB, width, '0, one));
      drive_cycle(1'b1, make_req(OP_RADD, width, smax, smax));
      drive_cycle(1'b1, make_req(OP_URADD, width, '1, '1));
      drive_cycle(1'b1, make_req(OP_RSUB, width, smin, smax));
      drive_cycle(1'b1, make_req(OP_URSUB, width, '0, one));
      drive_cycle(1'b0, make_req(OP_ADD, width, '0, '0));
      drive_cycle(1'b1, make_req(OP_SCMPLT, width, smin, smax));
      drive_cycle(1'b1, make_req(OP_UCMPLE, width, smin, smax));
      drive_cycle(1'b1, make_req(OP_SMIN, width, smin, smax));
      drive_cycle(1'b1, make_req(OP_UMAX, width, smin, smax));
    end
  endtask

  task automatic send_random();
    simd_req_t req;
    logic      valid;
    req.op        = simd_op_e'($urandom_range(0, 18));
    req.width     = simd_width_e'($urandom_range(0, 2));
    req.operand_a = pick_operand(req.width);
    req.operand_b = pick_operand(req.width);
    if ($urandom_range(0, 7) == 0) begin
      req.operand_b = req.operand_a;
    end
    valid = ($urandom_range(0, 9) < 8);
    drive_cycle(valid, req);
  endtask

  ////////////////////
  // Response checks
  ////////////////////
  // Runs mid-cycle, after the driver has pushed this cycle's request
  task automatic check_response();
    simd_req_t req;
    simd_rsp_t exp;
    string     name;
    int        outstanding;
    outstanding = pending.size() - (valid_i ? 1 : 0);
    assert (valid_o === (outstanding > 0)) else begin
      $display("valid_o is %b while %0d request(s) were due a response", valid_o, outstanding);
      protocol_errors++;
    end
    if (outstanding > 0) begin
      req = pending.pop_front();
      if (valid_o === 1'b1) begin
        exp      = model_response(req);
        name     = $sformatf("%s_%s", req.op.name(), req.width.name());
        held_rsp = exp;
        checks++;
        assert (rsp_o.result === exp.result) else begin
          $display("error %s.result expected %h actual %h", name, exp.result, rsp_o.result);
          value_errors++;
        end
        assert (rsp_o.ov === exp.ov) else begin
          $display("error %s.ov expected %b actual %b", name, exp.ov, rsp_o.ov);
          value_errors++;
        end
      end
    end else begin
      // Idle cycle keeps the last response
      assert (rsp_o === held_rsp) else begin
        $display("error rsp_hold expected %h actual %h", held_rsp, rsp_o);
        value_errors++;
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      check_response();
    end
  end

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (pending.size() > 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (pending.size() > 0) begin
      $display("timeout: %0d response(s) never arrived", pending.size());
      protocol_errors++;
    end
  endtask

  initial begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    valid_i         = 1'b0;
    req_i           = '0;
    held_rsp        = '0;
    checks          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    void'($urandom(RNG_SEED));
    repeat (RESET_CYCLES) @(posedge clk_i);
    assert (valid_o === 1'b0 && rsp_o === '0) else begin
      $display("outputs were not cleared by reset");
      protocol_errors++;
    end
    #1;
    arst_n_i = 1'b1;
    send_edge_cases();
    for (int n = 0; n < NUM_RANDOM; n++) begin
      send_random();
    end
    drive_cycle(1'b0, '0);
    wait_for_drain();
    // Idle cycles so valid_o is seen low again
    repeat (2) drive_cycle(1'b0, '0);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checks, value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== tests/simd_alu_props.sv ====
////////////////////
// Protocol assertions for the SIMD ALU
// Bound to the top level, watching reset, valid timing and the ov flag
////////////////////
module simd_alu_props (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    valid_i,
  input simd_alu_pkg::simd_req_t req_i,
  input logic                    valid_o,
  input simd_alu_pkg::simd_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import simd_alu_pkg::*;

  logic sat_req;

  // Accepted request of a saturating op
  assign sat_req = valid_i && (req_i.op inside {OP_KADD, OP_UKADD, OP_KSUB, OP_UKSUB});

  // Output register stays cleared under reset
  reset_clears_valid: assert property (@(posedge clk_i) !arst_n_i |-> !valid_o)
    else $error("valid_o is high while reset is active");

  // Exactly one cycle of latency
  valid_follows_input: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(arst_n_i) |-> (valid_o == $past(valid_i)))
    else $error("valid_o does not follow valid_i of the previous cycle");

  ov_only_after_sat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_o && rsp_o.ov) |-> $past(sat_req))
    else $error("ov is set for a request that was not a saturating operation");

endmodule

bind simd_alu simd_alu_props u_props (.*);

// ==== source/simd_alu.sv ====
////////////////////
// Packed-SIMD integer ALU, top level
// One request per cycle in, its response one cycle later
////////////////////
module simd_alu (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  simd_alu_pkg::simd_req_t req_i,
  output logic                    valid_o,
  output simd_alu_pkg::simd_rsp_t rsp_o
);

  import simd_alu_pkg::*;

  logic [DATA_W-1:0] arith_result;
  logic              arith_ov;
  logic [DATA_W-1:0] cmp_result;

  // Both paths see the request in parallel
  simd_arith u_arith (
    .req_i    (req_i),
    .result_o (arith_result),
    .ov_o     (arith_ov)
  );

  simd_compare u_compare (
    .req_i    (req_i),
    .result_o (cmp_result)
  );

  simd_result_sel u_result_sel (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .valid_i        (valid_i),
    .op_i           (req_i.op),
    .arith_result_i (arith_result),
    .cmp_result_i   (cmp_result),
    .arith_ov_i     (arith_ov),
    .valid_o        (valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

// ==== source/simd_result_sel.sv ====
////////////////////
// Result selector and output register of the SIMD ALU
// Picks the arithmetic or compare result and registers it with its valid
////////////////////
module simd_result_sel (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  input  simd_alu_pkg::simd_op_e          op_i,
  input  logic [simd_alu_pkg::DATA_W-1:0] arith_result_i,
  input  logic [simd_alu_pkg::DATA_W-1:0] cmp_result_i,
  input  logic                            arith_ov_i,
  output logic                            valid_o,
  output simd_alu_pkg::simd_rsp_t         rsp_o
);

  import simd_alu_pkg::*;

  logic      is_arith;
  simd_rsp_t rsp_d;

  // Operation class
  always_comb begin
    case (op_i)
      OP_ADD, OP_SUB,
      OP_KADD, OP_UKADD,
      OP_KSUB, OP_UKSUB,
      OP_RADD, OP_URADD,
      OP_RSUB, OP_URSUB: is_arith = 1'b1;
      default:           is_arith = 1'b0;
    endcase
  end

  // ov is already zero outside the saturating ops
  always_comb begin
    rsp_d.result = is_arith ? arith_result_i : cmp_result_i;
    rsp_d.ov     = arith_ov_i;
  end

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      rsp_o   <= '0;
    end else begin
      valid_o <= valid_i;
      // Response holds while no request arrives
      if (valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

// ==== source/simd_compare.sv ====
////////////////////
// Compare path of the SIMD ALU
// Lane masks for compares and operand selection for min/max
////////////////////
module simd_compare (
  input  simd_alu_pkg::simd_req_t         req_i,
  output logic [simd_alu_pkg::DATA_W-1:0] result_o
);

  import simd_alu_pkg::*;

  logic                 cmp_signed;
  logic                 is_minmax;
  logic                 pick_a_on_lt;
  logic [NUM_BYTES-1:0] lane_top;
  logic [NUM_BYTES-1:0] byte_eq;
  logic [NUM_BYTES-1:0] byte_lt;
  logic [NUM_BYTES-1:0] lane_eq;
  logic [NUM_BYTES-1:0] lane_lt;
  logic [NUM_BYTES-1:0] lane_flag;

  assign lane_top = lane_top_mask(req_i.width);

  always_comb begin
    cmp_signed = 1'b0;
    case (req_i.op)
      OP_SCMPLT, OP_SCMPLE, OP_SMIN, OP_SMAX: cmp_signed = 1'b1;
      default:                                cmp_signed = 1'b0;
    endcase
  end

  ////////////////////
  // Byte compares
  ////////////////////
  always_comb begin
    logic [LANE_W-1:0] a_byte;
    logic [LANE_W-1:0] b_byte;
    for (int b = 0; b < NUM_BYTES; b++) begin
      a_byte     = req_i.operand_a[LANE_W*b +: LANE_W];
      b_byte     = req_i.operand_b[LANE_W*b +: LANE_W];
      byte_eq[b] = (a_byte == b_byte);
      // Sign matters only in the top byte of a lane
      if (lane_top[b] && cmp_signed) begin
        byte_lt[b] = $signed(a_byte) < $signed(b_byte);
      end else begin
        byte_lt[b] = a_byte < b_byte;
      end
    end
  end

  ////////////////////
  // Lane merge
  ////////////////////
  // Walk up from the low byte, higher bytes decide unless equal
  always_comb begin
    logic start;
    logic acc_eq;
    logic acc_lt;
    start  = 1'b1;
    acc_eq = 1'b0;
    acc_lt = 1'b0;
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (start) begin
        acc_eq = byte_eq[b];
        acc_lt = byte_lt[b];
      end else begin
        acc_lt = byte_lt[b] | (byte_eq[b] & acc_lt);
        acc_eq = byte_eq[b] & acc_eq;
      end
      start      = lane_top[b];
      lane_eq[b] = acc_eq;
      lane_lt[b] = acc_lt;
    end
  end

  // Flag per op, then copy the top byte flag down the lane
  always_comb begin
    logic flag;
    flag = 1'b0;
    for (int b = NUM_BYTES - 1; b >= 0; b--) begin
      if (lane_top[b]) begin
        case (req_i.op)
          OP_CMPEQ:             flag = lane_eq[b];
          OP_SCMPLE, OP_UCMPLE: flag = lane_lt[b] | lane_eq[b];
          default:              flag = lane_lt[b];
        endcase
      end
      lane_flag[b] = flag;
    end
  end

  ////////////////////
  // Output select
  ////////////////////
  assign is_minmax    = (req_i.op inside {OP_SMIN, OP_SMAX, OP_UMIN, OP_UMAX});
  assign pick_a_on_lt = (req_i.op inside {OP_SMIN, OP_UMIN});

  always_comb begin
    result_o = '0;
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (is_minmax) begin
        // Min keeps a when a < b, max keeps a when a >= b
        result_o[LANE_W*b +: LANE_W] = (lane_flag[b] == pick_a_on_lt)
                                       ? req_i.operand_a[LANE_W*b +: LANE_W]
                                       : req_i.operand_b[LANE_W*b +: LANE_W];
      end else if (req_i.op inside {OP_CMPEQ, OP_SCMPLT, OP_SCMPLE, OP_UCMPLT, OP_UCMPLE}) begin
        result_o[LANE_W*b +: LANE_W] = {LANE_W{lane_flag[b]}};
      end
    end
  end

endmodule

// ==== source/simd_arith.sv ====
////////////////////
// Arithmetic path of the SIMD ALU
// Wrapping, saturating and halving add/sub per lane, purely combinational
////////////////////
module simd_arith (
  input  simd_alu_pkg::simd_req_t         req_i,
  output logic [simd_alu_pkg::DATA_W-1:0] result_o,
  output logic                            ov_o
);

  import simd_alu_pkg::*;

  ////////////////////
  // Decode
  ////////////////////
  logic is_sub;
  logic is_signed;
  logic is_sat;
  logic is_halve;

  always_comb begin
    is_sub    = 1'b0;
    is_signed = 1'b0;
    is_sat    = 1'b0;
    is_halve  = 1'b0;
    case (req_i.op)
      OP_SUB:   is_sub = 1'b1;
      OP_KADD:  begin is_signed = 1'b1; is_sat = 1'b1; end
      OP_UKADD: is_sat = 1'b1;
      OP_KSUB:  begin is_sub = 1'b1; is_signed = 1'b1; is_sat = 1'b1; end
      OP_UKSUB: begin is_sub = 1'b1; is_sat = 1'b1; end
      OP_RADD:  begin is_signed = 1'b1; is_halve = 1'b1; end
      OP_URADD: is_halve = 1'b1;
      OP_RSUB:  begin is_sub = 1'b1; is_signed = 1'b1; is_halve = 1'b1; end
      OP_URSUB: begin is_sub = 1'b1; is_halve = 1'b1; end
      default:  ;
    endcase
  end

  ////////////////////
  // Lane adder
  ////////////////////
  logic [DATA_W-1:0]    operand_b;
  logic [NUM_BYTES-1:0] lane_top;
  simd_lane_sum_t       sum;

  // Subtract as a + ~b + 1, the +1 enters at each lane start
  assign operand_b = is_sub ? ~req_i.operand_b : req_i.operand_b;
  assign lane_top  = lane_top_mask(req_i.width);

  simd_lane_adder u_lane_adder (
    .a_i        (req_i.operand_a),
    .b_i        (operand_b),
    .carry_in_i ({NUM_BYTES{is_sub}}),
    .width_i    (req_i.width),
    .signed_i   (is_signed),
    .sum_o      (sum)
  );

  ////////////////////
  // Lane results
  ////////////////////
  logic [DATA_W-1:0]    wrapped;
  logic [DATA_W-1:0]    halved;
  logic [DATA_W-1:0]    saturated;
  logic [DATA_W-1:0]    s_max;
  logic [DATA_W-1:0]    s_min;
  logic [DATA_W-1:0]    u_max;
  logic [NUM_BYTES-1:0] top9;
  logic [NUM_BYTES-1:0] byte_ovf;
  logic [NUM_BYTES-1:0] next_lsb;
  logic [NUM_BYTES-1:0] lane_clamp;
  logic [NUM_BYTES-1:0] lane_neg;
  logic [NUM_BYTES-1:0] sum_lsb;

  // Clamp patterns for the current lane width
  always_comb begin
    case (req_i.width)
      W8: begin
        s_max = {NUM_BYTES{SAT_S8_MAX}};
        s_min = {NUM_BYTES{SAT_S8_MIN}};
        u_max = {NUM_BYTES{SAT_U8_MAX}};
      end
      W16: begin
        s_max = {2{SAT_S16_MAX}};
        s_min = {2{SAT_S16_MIN}};
        u_max = '1;
      end
      default: begin
        s_max = SAT_S32_MAX;
        s_min = SAT_S32_MIN;
        u_max = '1;
      end
    endcase
  end

  always_comb begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      wrapped[LANE_W*b +: LANE_W] = sum.lane[b][LANE_W-1:0];
      sum_lsb[b] = sum.lane[b][0];
      // Unsigned subtract carries an inverted borrow in bit 8
      top9[b] = sum.lane[b][LANE_W] ^ (is_sub & ~is_signed);
      if (is_signed) begin
        byte_ovf[b] = lane_top[b] & (top9[b] ^ sum.lane[b][LANE_W-1]);
      end else begin
        byte_ovf[b] = lane_top[b] & top9[b];
      end
    end
  end

  assign next_lsb = {1'b0, sum_lsb[NUM_BYTES-1:1]};

  // Shift right by one, lane top takes the ninth bit
  always_comb begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      halved[LANE_W*b +: LANE_W] = {lane_top[b] ? top9[b] : next_lsb[b],
                                    sum.lane[b][LANE_W-1:1]};
    end
  end

  // Spread the top-byte overflow state down through each lane
  always_comb begin
    logic cl;
    logic neg;
    cl  = 1'b0;
    neg = 1'b0;
    for (int b = NUM_BYTES - 1; b >= 0; b--) begin
      if (lane_top[b]) begin
        cl  = byte_ovf[b];
        neg = top9[b];
      end
      lane_clamp[b] = cl;
      lane_neg[b]   = neg;
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (!lane_clamp[b]) begin
        saturated[LANE_W*b +: LANE_W] = wrapped[LANE_W*b +: LANE_W];
      end else if (is_signed) begin
        saturated[LANE_W*b +: LANE_W] = lane_neg[b] ? s_min[LANE_W*b +: LANE_W]
                                                    : s_max[LANE_W*b +: LANE_W];
      end else begin
        // Unsigned underflow goes to zero
        saturated[LANE_W*b +: LANE_W] = is_sub ? '0 : u_max[LANE_W*b +: LANE_W];
      end
    end
  end

  assign result_o = is_halve ? halved : (is_sat ? saturated : wrapped);
  assign ov_o     = is_sat & (|byte_ovf);

endmodule

// ==== source/simd_lane_adder.sv ====
////////////////////
// Byte-sliced adder for the SIMD arithmetic path
// Carries chain inside a lane and break at lane boundaries
////////////////////
module simd_lane_adder (
  input  logic [simd_alu_pkg::DATA_W-1:0]    a_i,
  input  logic [simd_alu_pkg::DATA_W-1:0]    b_i,
  input  logic [simd_alu_pkg::NUM_BYTES-1:0] carry_in_i,
  input  simd_alu_pkg::simd_width_e          width_i,
  input  logic                               signed_i,
  output simd_alu_pkg::simd_lane_sum_t       sum_o
);

  import simd_alu_pkg::*;

  logic [NUM_BYTES-1:0]           lane_top;
  logic [NUM_BYTES-1:0][LANE_W:0] sums;

  assign lane_top = lane_top_mask(width_i);

  for (genvar b = 0; b < NUM_BYTES; b++) begin : g_byte
    logic [LANE_W-1:0] a_byte;
    logic [LANE_W-1:0] b_byte;
    logic              ext_a;
    logic              ext_b;
    logic              cin;

    assign a_byte = a_i[LANE_W*b +: LANE_W];
    assign b_byte = b_i[LANE_W*b +: LANE_W];

    // Only the top byte of a signed lane is sign extended
    assign ext_a = signed_i & lane_top[b] & a_byte[LANE_W-1];
    assign ext_b = signed_i & lane_top[b] & b_byte[LANE_W-1];

    if (b == 0) begin : g_first
      assign cin = carry_in_i[0];
    end else begin : g_chain
      // Lane boundary below takes the external carry, else chain
      assign cin = lane_top[b-1] ? carry_in_i[b] : sums[b-1][LANE_W];
    end

    assign sums[b] = {ext_a, a_byte} + {ext_b, b_byte} + {{LANE_W{1'b0}}, cin};
  end

  assign sum_o.lane = sums;

endmodule

// ==== source/simd_alu_pkg.sv ====
////////////////////
// Shared definitions for the packed-SIMD ALU
// Widths, clamp constants, operation encodings and request/response structs
// Imported by every RTL module of the ALU
////////////////////
package simd_alu_pkg;

  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_BYTES = 4;

  // Signed clamp values per lane width
  localparam logic [7:0]  SAT_S8_MAX  = 8'h7f;
  localparam logic [7:0]  SAT_S8_MIN  = 8'h80;
  localparam logic [15:0] SAT_S16_MAX = 16'h7fff;
  localparam logic [15:0] SAT_S16_MIN = 16'h8000;
  localparam logic [31:0] SAT_S32_MAX = 32'h7fff_ffff;
  localparam logic [31:0] SAT_S32_MIN = 32'h8000_0000;

  // Unsigned byte clamp, wider lanes use all ones
  localparam logic [7:0]  SAT_U8_MAX  = 8'hff;

  typedef enum logic [1:0] {
    W8  = 2'd0,
    W16 = 2'd1,
    W32 = 2'd2
  } simd_width_e;

  typedef enum logic [4:0] {
    // Arithmetic path
    OP_ADD    = 5'd0,
    OP_SUB    = 5'd1,
    OP_KADD   = 5'd2,
    OP_UKADD  = 5'd3,
    OP_KSUB   = 5'd4,
    OP_UKSUB  = 5'd5,
    OP_RADD   = 5'd6,
    OP_URADD  = 5'd7,
    OP_RSUB   = 5'd8,
    OP_URSUB  = 5'd9,
    // Compare path
    OP_CMPEQ  = 5'd10,
    OP_SCMPLT = 5'd11,
    OP_SCMPLE = 5'd12,
    OP_UCMPLT = 5'd13,
    OP_UCMPLE = 5'd14,
    OP_SMIN   = 5'd15,
    OP_SMAX   = 5'd16,
    OP_UMIN   = 5'd17,
    OP_UMAX   = 5'd18
  } simd_op_e;

  typedef struct packed {
    simd_op_e          op;
    simd_width_e       width;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
  } simd_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic              ov;
  } simd_rsp_t;

  // Bit 8 of each entry is the carry or the sign-extended ninth bit
  typedef struct packed {
    logic [NUM_BYTES-1:0][LANE_W:0] lane;
  } simd_lane_sum_t;

  // One bit per byte, set where a byte is the top byte of its lane
  function automatic logic [NUM_BYTES-1:0] lane_top_mask(simd_width_e width);
    case (width)
      W8:      return 4'b1111;
      W16:     return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

endpackage
